// ==== hw/prog_fifo.sv ====
// request queue between router and SDRAM writer
// circular buffer with a level count; shows the two oldest entries
// so that a byte pair can leave together, and throttles the loader
`timescale 1ns/1ps
`default_nettype none

module prog_fifo (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             push,
    input  logic [sdram_req_pkg::REQ_W-1:0]  push_req,
    output logic [sdram_req_pkg::REQ_W-1:0]  head_req,
    output logic                             head_valid,
    output logic [sdram_req_pkg::REQ_W-1:0]  next_req,
    output logic                             next_valid,
    input  logic                             pop,
    input  logic                             pop_two,
    output logic                             ioctl_wait,
    output logic                             fifo_empty
);
    import sdram_req_pkg::*;

    logic [REQ_W-1:0] mem [0:FIFO_DEPTH-1];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [LVL_W-1:0] level;
    logic [LVL_W-1:0] pop_cnt;

    always_comb begin
        if (!pop)
            pop_cnt = '0;
        else if (pop_two)
            pop_cnt = LVL_W'(2);
        else
            pop_cnt = LVL_W'(1);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + PTR_W'(1);
            rd_ptr <= rd_ptr + pop_cnt[PTR_W-1:0];  // wraps with depth 2**n
            level  <= level + LVL_W'(push) - pop_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_req;
    end

    assign head_req   = mem[rd_ptr];
    assign next_req   = mem[rd_ptr + PTR_W'(1)];
    assign head_valid = level != '0;
    assign next_valid = level >= LVL_W'(2);
    assign fifo_empty = level == '0;
    assign ioctl_wait = level >= LVL_W'(WAIT_LEVEL);  // early, room for in-flight byte

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!arst_n)
        push |-> (level < LVL_W'(FIFO_DEPTH) || pop)
    ) else $error("push into full request FIFO");

    a_no_underflow: assert property (
        @(posedge clk) disable iff (!arst_n)
        pop |-> level >= pop_cnt
    ) else $error("pop beyond FIFO level");

endmodule

`default_nettype wire

// ==== hw/rom_layout_pkg.sv ====
// rom download layout
// header offsets, region encoding, per-region placement in SDRAM
// and the fixed byte substitution used on encrypted CPU code
`default_nettype none

package rom_layout_pkg;

    localparam logic [25:0] START_BYTES = 26'd8;   // sound, pcm, gfx, spare marks
    localparam logic [25:0] CFG_FIRST   = 26'd8;
    localparam logic [25:0] CFG_LAST    = 26'd39;
    localparam logic [25:0] CFG_BYTE    = 26'd39;  // decrypt enable and selector
    localparam logic [25:0] FULL_HEADER = 26'd64;  // bulk data starts here
    localparam int          DECRYPT_ABIT = 12;

    // word offsets inside each bank
    localparam logic [22:0] CPU_OFFSET = 23'h000000;
    localparam logic [22:0] SND_OFFSET = 23'h080000;  // above cpu code in bank 0
    localparam logic [22:0] PCM_OFFSET = 23'h000000;
    localparam logic [22:0] GFX_OFFSET = 23'h000000;

    // xor contribution of each set input bit
    localparam logic [7:0] DEC_SET [0:7] = '{
        8'h04, 8'h21, 8'h01, 8'h00, 8'h40, 8'h06, 8'h08, 8'h00
    };

    typedef enum logic [2:0] {
        REGION_NONE,
        REGION_CPU,
        REGION_SND,
        REGION_PCM,
        REGION_GFX
    } rom_region_e;

    function automatic logic [1:0] region_bank(input rom_region_e region);
        logic [1:0] bank;
        case (region)
            REGION_PCM: bank = 2'd1;
            REGION_GFX: bank = 2'd2;
            default:    bank = 2'd0;  // cpu and sound share bank 0
        endcase
        return bank;
    endfunction

    // bit substitution table for protected CPU code
    function automatic logic [7:0] cpu_decrypt(input logic [7:0] din);
        logic [7:0] res;
        res = 8'h00;
        for (int i = 0; i < 8; i++) begin
            if (din[i])
                res = res ^ DEC_SET[i];
        end
        if (!din[3])
            res = res ^ 8'h50;  // inverted contribution
        if (!din[7])
            res = res ^ 8'h88;
        return res;
    endfunction

endpackage

`default_nettype wire

// ==== hw/rom_loader_top.sv ====
// rom loader top
// router feeds the request FIFO, the writer drains it into SDRAM
`timescale 1ns/1ps
`default_nettype none

module rom_loader_top (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        downloading,
    input  logic [25:0] ioctl_addr,
    input  logic [7:0]  ioctl_dout,
    input  logic        ioctl_wr,
    output logic        ioctl_wait,
    output logic        dwnld_busy,
    output logic        cfg_we,
    output logic [4:0]  cfg_addr,
    output logic [7:0]  cfg_data,
    output logic [22:0] prog_addr,
    output logic [15:0] prog_data,
    output logic [1:0]  prog_mask,
    output logic [1:0]  prog_ba,
    output logic        prog_we,
    input  logic        prog_rdy
);
    import sdram_req_pkg::*;

    logic             push;
    logic [REQ_W-1:0] push_req;
    logic [REQ_W-1:0] head_req;
    logic             head_valid;
    logic [REQ_W-1:0] next_req;
    logic             next_valid;
    logic             pop;
    logic             pop_two;
    logic             fifo_empty;
    logic             writer_idle;

    rom_router i_rom_router (.*);

    prog_fifo i_prog_fifo (.*);

    sdram_writer i_sdram_writer (.*);

    // busy until the last queued byte is acknowledged
    assign dwnld_busy = downloading || !fifo_empty || !writer_idle;

endmodule

`default_nettype wire

// ==== hw/rom_router.sv ====
// rom download router
// captures the start marks, forwards board configuration bytes and
// turns every bulk byte into an SDRAM request with bank, word address
// and odd-byte flag, decrypting protected CPU bytes on the way
`timescale 1ns/1ps
`default_nettype none

module rom_router (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             downloading,
    input  logic [25:0]                      ioctl_addr,
    input  logic [7:0]                       ioctl_dout,
    input  logic                             ioctl_wr,
    output logic                             push,
    output logic [sdram_req_pkg::REQ_W-1:0]  push_req,
    output logic                             cfg_we,
    output logic [4:0]                       cfg_addr,
    output logic [7:0]                       cfg_data
);
    import rom_layout_pkg::*;
    import sdram_req_pkg::*;

    logic [63:0]  starts;        // little endian kB marks
    logic [15:0]  snd_start;
    logic [15:0]  pcm_start;
    logic [15:0]  gfx_start;
    logic         decrypt_en;
    logic         sel_bit;

    logic [25:0]  bulk_addr;
    logic [25:0]  cfg_off;
    logic [15:0]  bulk_kb;
    logic         is_start;
    logic         is_cfg;
    rom_region_e  region;
    logic [15:0]  reg_start;
    logic [22:0]  reg_offset;
    logic [25:0]  rel_addr;
    logic         do_decrypt;
    logic [7:0]   bulk_data;
    logic [REQ_W-1:0] req_next;

    assign snd_start = starts[15:0];
    assign pcm_start = starts[31:16];
    assign gfx_start = starts[47:32];

    assign bulk_addr = ioctl_addr - FULL_HEADER;  // header excluded
    assign cfg_off   = ioctl_addr - CFG_FIRST;
    assign bulk_kb   = bulk_addr[25:10];
    assign is_start  = ioctl_addr < START_BYTES;
    assign is_cfg    = ioctl_addr >= CFG_FIRST && ioctl_addr <= CFG_LAST;

    // region from kB index against the marks
    always_comb begin
        if (ioctl_addr < FULL_HEADER)
            region = REGION_NONE;  // header and reserved bytes
        else if (bulk_kb < snd_start)
            region = REGION_CPU;
        else if (bulk_kb < pcm_start)
            region = REGION_SND;
        else if (bulk_kb < gfx_start)
            region = REGION_PCM;
        else
            region = REGION_GFX;
    end

    always_comb begin
        case (region)
            REGION_SND: begin
                reg_start  = snd_start;
                reg_offset = SND_OFFSET;
            end
            REGION_PCM: begin
                reg_start  = pcm_start;
                reg_offset = PCM_OFFSET;
            end
            REGION_GFX: begin
                reg_start  = gfx_start;
                reg_offset = GFX_OFFSET;
            end
            default: begin
                reg_start  = 16'd0;    // cpu code starts the bulk
                reg_offset = CPU_OFFSET;
            end
        endcase
    end

    assign rel_addr = bulk_addr - {reg_start, 10'd0};

    // only one byte lane of the upper cpu area is encrypted
    assign do_decrypt = region == REGION_CPU && decrypt_en &&
                        bulk_addr[DECRYPT_ABIT] && (bulk_addr[0] ^ sel_bit);
    assign bulk_data  = do_decrypt ? cpu_decrypt(ioctl_dout) : ioctl_dout;

    always_comb begin
        req_next = '0;  // spare bits stay low
        req_next[REQ_ADDR_LSB +: 23] = rel_addr[23:1] + reg_offset;
        req_next[REQ_DATA_LSB +: 8]  = bulk_data;
        req_next[REQ_BANK_LSB +: 2]  = region_bank(region);
        req_next[REQ_ODD_BIT]        = ioctl_addr[0];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            starts     <= '0;
            push       <= 1'b0;
            cfg_we     <= 1'b0;
            decrypt_en <= 1'b0;
            sel_bit    <= 1'b0;
        end else begin
            push   <= ioctl_wr && region != REGION_NONE;
            cfg_we <= ioctl_wr && is_cfg;
            if (ioctl_wr && is_start)
                starts <= {ioctl_dout, starts[63:8]};  // shift in from the top
            if (ioctl_wr && ioctl_addr == CFG_BYTE) begin
                decrypt_en <= ioctl_dout[7];
                sel_bit    <= ioctl_dout[6];
            end else if (!downloading) begin
                decrypt_en <= 1'b0;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (ioctl_wr) begin
            push_req <= req_next;
            cfg_addr <= cfg_off[4:0];
            cfg_data <= ioctl_dout;
        end
    end

    // marks must describe ordered regions once the bulk begins
    a_marks_ordered: assert property (
        @(posedge clk) disable iff (!arst_n)
        (ioctl_wr && ioctl_addr == FULL_HEADER) |->
            (snd_start <= pcm_start && pcm_start <= gfx_start)
    ) else $error("start marks out of order at first bulk byte");

endmodule

`default_nettype wire

// ==== hw/sdram_req_pkg.sv ====
// SDRAM request side definitions
// queue sizing, request word layout, byte masks and writer FSM states
`default_nettype none

package sdram_req_pkg;

    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int LVL_W      = $clog2(FIFO_DEPTH + 1);
    localparam int WAIT_LEVEL = FIFO_DEPTH - 2;  // one byte in flight plus one

    // request word: addr, data, bank, odd flag, spare
    localparam int REQ_W        = 37;
    localparam int REQ_ADDR_LSB = 0;
    localparam int REQ_DATA_LSB = 23;
    localparam int REQ_BANK_LSB = 31;
    localparam int REQ_ODD_BIT  = 33;

    // prog_mask is active low
    localparam logic [1:0] MASK_LOW  = 2'b10;
    localparam logic [1:0] MASK_HIGH = 2'b01;
    localparam logic [1:0] MASK_WORD = 2'b00;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_HOLD
    } writer_state_e;

endpackage

`default_nettype wire

// ==== hw/sdram_writer.sv ====
// SDRAM download writer
// takes requests from the queue head, merges an even byte with the
// following odd byte of the same word into one word write, and keeps
// the port stable until the memory controller acknowledges
`timescale 1ns/1ps
`default_nettype none

module sdram_writer (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic [sdram_req_pkg::REQ_W-1:0]  head_req,
    input  logic                             head_valid,
    input  logic [sdram_req_pkg::REQ_W-1:0]  next_req,
    input  logic                             next_valid,
    output logic                             pop,
    output logic                             pop_two,
    output logic [22:0]                      prog_addr,
    output logic [15:0]                      prog_data,
    output logic [1:0]                       prog_mask,
    output logic [1:0]                       prog_ba,
    output logic                             prog_we,
    input  logic                             prog_rdy,
    output logic                             writer_idle
);
    import sdram_req_pkg::*;

    writer_state_e state;

    logic [22:0] h_addr;
    logic [7:0]  h_data;
    logic [1:0]  h_ba;
    logic        h_odd;
    logic [22:0] n_addr;
    logic [7:0]  n_data;
    logic [1:0]  n_ba;
    logic        n_odd;
    logic        merge;

    assign h_addr = head_req[REQ_ADDR_LSB +: 23];
    assign h_data = head_req[REQ_DATA_LSB +: 8];
    assign h_ba   = head_req[REQ_BANK_LSB +: 2];
    assign h_odd  = head_req[REQ_ODD_BIT];
    assign n_addr = next_req[REQ_ADDR_LSB +: 23];
    assign n_data = next_req[REQ_DATA_LSB +: 8];
    assign n_ba   = next_req[REQ_BANK_LSB +: 2];
    assign n_odd  = next_req[REQ_ODD_BIT];

    // even byte followed by its odd partner
    assign merge = next_valid && !h_odd && n_odd && n_addr == h_addr && n_ba == h_ba;

    assign pop         = state == ST_IDLE && head_valid;
    assign pop_two     = pop && merge;
    assign writer_idle = state == ST_IDLE;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            prog_we <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (head_valid)
                        state <= ST_ISSUE;
                end
                ST_ISSUE: begin
                    prog_we <= 1'b1;
                    state   <= ST_HOLD;
                end
                ST_HOLD: begin
                    if (prog_rdy) begin  // ack seen, release port
                        prog_we <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // port payload, loaded only when an entry is taken
    always_ff @(posedge clk) begin
        if (pop) begin
            prog_addr <= h_addr;
            prog_ba   <= h_ba;
            if (merge) begin
                prog_data <= {n_data, h_data};  // odd byte in upper half
                prog_mask <= MASK_WORD;
            end else begin
                prog_data <= {2{h_data}};
                prog_mask <= h_odd ? MASK_HIGH : MASK_LOW;
            end
        end
    end

    a_port_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        (prog_we && !prog_rdy) |=> (prog_we && $stable(prog_addr) &&
            $stable(prog_data) && $stable(prog_mask) && $stable(prog_ba))
    ) else $error("SDRAM port changed before acknowledge");

endmodule

`default_nettype wire

// ==== rom_loader.f ====
hw/rom_layout_pkg.sv
hw/sdram_req_pkg.sv
hw/rom_router.sv
hw/prog_fifo.sv
hw/sdram_writer.sv
hw/rom_loader_top.sv
test/rom_loader_tb.sv

// ==== test/rom_loader_tb.sv ====
// rom loader testbench
// two random downloads through the loader port, an SDRAM responder with
// random acknowledge delay, a reference memory and config strobe checks
`timescale 1ns/1ps
`default_nettype none

module rom_loader_tb;
    import rom_layout_pkg::*;
    import sdram_req_pkg::*;

    localparam int MAX_GAP = 6;  // most idle cycles between strobes

    logic        clk;
    logic        arst_n;
    logic        downloading;
    logic [25:0] ioctl_addr;
    logic [7:0]  ioctl_dout;
    logic        ioctl_wr;
    logic        ioctl_wait;
    logic        dwnld_busy;
    logic        cfg_we;
    logic [4:0]  cfg_addr;
    logic [7:0]  cfg_data;
    logic [22:0] prog_addr;
    logic [15:0] prog_data;
    logic [1:0]  prog_mask;
    logic [1:0]  prog_ba;
    logic        prog_we;
    logic        prog_rdy;

    integer      seed;
    longint      budget_ns;
    int          lay_snd [0:1];  // kB marks per download
    int          lay_pcm [0:1];
    int          lay_gfx [0:1];
    int          lay_len [0:1];
    logic [7:0]  exp_byte [int];  // key {bank, word, lane}
    logic [7:0]  got_byte [int];
    logic [12:0] cfg_exp [$];     // {cfg_addr, cfg_data}
    logic        slow_mode;
    logic        wait_seen;
    logic        in_write;
    int          ack_delay;
    int          merged_writes;
    logic [42:0] cap_port;        // {ba, mask, data, addr} of the pending write

    rom_loader_top i_rom_loader_top (.*);

    always #5 clk = ~clk;

    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    function automatic int rand_below(input int n);
        return {$random(seed)} % n;
    endfunction

    // substitution for protected CPU bytes where bits 3 and 7 count when clear
    function automatic logic [7:0] substitute_byte(input logic [7:0] raw);
        logic [7:0] res;
        res = ({8{raw[0]}} & 8'h04) ^ ({8{raw[1]}} & 8'h21) ^ ({8{raw[2]}} & 8'h01) ^
              ({8{raw[4]}} & 8'h40) ^ ({8{raw[5]}} & 8'h06) ^ ({8{raw[6]}} & 8'h08);
        return res ^ (raw[3] ? 8'h00 : 8'h50) ^ (raw[7] ? 8'h00 : 8'h88);
    endfunction

    // expected bank, word and lane of one bulk byte
    task automatic model_bulk(input int idx, input int addr, input logic [7:0] raw,
                              input logic dec_en, input logic sel);
        int         b;
        int         bank;
        int         word;
        logic [7:0] val;
        b    = addr - FULL_HEADER;
        val  = raw;
        bank = 0;
        if (b / 1024 < lay_snd[idx]) begin
            word = b / 2 + CPU_OFFSET;
            if (dec_en && b[12] && (b[0] != sel))
                val = substitute_byte(raw);
        end else if (b / 1024 < lay_pcm[idx]) begin
            word = (b - lay_snd[idx] * 1024) / 2 + SND_OFFSET;
        end else if (b / 1024 < lay_gfx[idx]) begin
            bank = 1;
            word = (b - lay_pcm[idx] * 1024) / 2 + PCM_OFFSET;
        end else begin
            bank = 2;
            word = (b - lay_gfx[idx] * 1024) / 2 + GFX_OFFSET;
        end
        exp_byte[{bank[1:0], word[22:0], b[0]}] = val;
    endtask

    task automatic store_write();
        logic [25:0] key;
        key = {cap_port[42:41], cap_port[22:0], cap_port[39]};  // lane of a byte write
        if (cap_port[40:39] == 2'b11) begin
            $display("SDRAM write with both byte lanes masked at word %h", cap_port[22:0]);
            stop_run();
        end else begin
            if (cap_port[40:39] == MASK_WORD)
                merged_writes++;
            else if (exp_byte.exists(key))
                check_value("prog_data", cap_port[38:23], {2{exp_byte[key]}});
            for (int lane = 0; lane < 2; lane++) begin
                if (!cap_port[39 + lane] &&
                    got_byte.exists({cap_port[42:41], cap_port[22:0], lane[0]})) begin
                    $display("byte lane %0d written twice at word %h", lane, cap_port[22:0]);
                    stop_run();
                end else if (!cap_port[39 + lane]) begin
                    got_byte[{cap_port[42:41], cap_port[22:0], lane[0]}] =
                        cap_port[23 + lane * 8 +: 8];
                end
            end
        end
    endtask

    // SDRAM responder acknowledging after a random delay
    always @(negedge clk) begin
        if (prog_rdy) begin
            check_value("prog_we after ack", prog_we, 1'b0);
            prog_rdy = 1'b0;
            in_write = 1'b0;
        end else if (prog_we) begin
            if (!in_write) begin
                in_write  = 1'b1;
                cap_port  = {prog_ba, prog_mask, prog_data, prog_addr};
                ack_delay = slow_mode ? 6 + rand_below(6) : rand_below(6);
            end else begin
                check_value("prog port held", {prog_ba, prog_mask, prog_data, prog_addr},
                            cap_port);
            end
            if (ack_delay == 0) begin
                store_write();
                prog_rdy = 1'b1;
            end else begin
                ack_delay--;
            end
        end
    end

    always @(posedge clk) begin
        if (arst_n) begin
            if (ioctl_wait)
                wait_seen = 1'b1;
            if ((downloading || prog_we) && !dwnld_busy) begin
                $display("dwnld_busy low while a download or write is active");
                stop_run();
            end
            if (cfg_we && cfg_exp.size() == 0) begin
                $display("cfg_we pulse without a configuration byte");
                stop_run();
            end else if (cfg_we) begin
                check_value("cfg_addr", cfg_addr, cfg_exp[0][12:8]);
                check_value("cfg_data", cfg_data, cfg_exp[0][7:0]);
                void'(cfg_exp.pop_front());
            end
        end
    end

    task automatic send_byte(input logic [25:0] addr, input logic [7:0] data);
        repeat (1 + rand_below(MAX_GAP)) @(negedge clk);
        while (ioctl_wait)
            @(negedge clk);
        ioctl_addr = addr;
        ioctl_dout = data;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr   = 1'b0;
    endtask

    task automatic run_download(input int idx, input logic dec_en);
        logic [7:0] hdr [0:63];
        logic [7:0] data;
        logic       sel;
        exp_byte.delete();
        got_byte.delete();
        wait_seen     = 1'b0;
        merged_writes = 0;
        slow_mode     = idx == 1;
        sel           = rand_below(2);
        for (int i = 0; i < 64; i++)
            hdr[i] = rand_below(256);
        hdr[0]  = lay_snd[idx][7:0];
        hdr[1]  = lay_snd[idx][15:8];
        hdr[2]  = lay_pcm[idx][7:0];
        hdr[3]  = lay_pcm[idx][15:8];
        hdr[4]  = lay_gfx[idx][7:0];
        hdr[5]  = lay_gfx[idx][15:8];
        hdr[39] = {dec_en, sel, hdr[39][5:0]};
        @(negedge clk);
        downloading = 1'b1;
        for (int a = 0; a < lay_len[idx]; a++) begin
            data = (a < 64) ? hdr[a] : rand_below(256);
            if (a >= CFG_FIRST && a <= CFG_LAST)
                cfg_exp.push_back({5'(a - 8), data});
            if (a >= FULL_HEADER)
                model_bulk(idx, a, data, dec_en, sel);
            send_byte(a, data);
        end
        repeat (4) @(negedge clk);  // last byte reaches the FIFO
        downloading = 1'b0;
        @(posedge clk);
        while (dwnld_busy)
            @(posedge clk);
        check_value("cfg strobes missing", cfg_exp.size(), 0);
        check_value("bytes written", got_byte.num(), exp_byte.num());
        foreach (exp_byte[k]) begin
            check_value("byte present", got_byte.exists(k), 1);
            check_value("sdram byte", got_byte[k], exp_byte[k]);
        end
        if (slow_mode) begin
            check_value("ioctl_wait seen", wait_seen, 1'b1);
            check_value("merged write seen", merged_writes > 0, 1'b1);
        end
    endtask

    initial begin
        wait (budget_ns > 0);
        #(budget_ns);
        $display("timeout, downloads not finished after %0d ns", budget_ns);
        stop_run();
    end

    initial begin
        clk           = 1'b0;
        arst_n        = 1'b0;
        downloading   = 1'b0;
        ioctl_addr    = '0;
        ioctl_dout    = '0;
        ioctl_wr      = 1'b0;
        prog_rdy      = 1'b0;
        in_write      = 1'b0;
        slow_mode     = 1'b0;
        wait_seen     = 1'b0;
        ack_delay     = 0;
        merged_writes = 0;
        budget_ns     = 0;
        seed          = 86997;
        for (int i = 0; i < 2; i++) begin
            lay_snd[i] = 5 + rand_below(2);  // cpu area spans the decrypt window
            lay_pcm[i] = lay_snd[i] + 1 + rand_below(2);
            lay_gfx[i] = lay_pcm[i] + 1;
            lay_len[i] = FULL_HEADER + lay_gfx[i] * 1024 + 256 + rand_below(256);
        end
        budget_ns = longint'(lay_len[0] + lay_len[1]) * (MAX_GAP + 8) * 10;
        repeat (16) @(posedge clk);
        @(negedge clk);
        check_value("prog_we", prog_we, 1'b0);
        check_value("cfg_we", cfg_we, 1'b0);
        check_value("ioctl_wait", ioctl_wait, 1'b0);
        check_value("dwnld_busy", dwnld_busy, 1'b0);
        arst_n = 1'b1;
        run_download(0, 1'b1);
        run_download(1, 1'b0);
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
